// File: verilog/wakeup_defs.svh
`ifndef WAKEUP_DEFS_SVH
`define WAKEUP_DEFS_SVH

// ****************************************
// issue and wakeup port counts
// ****************************************

`define ALU_SIZE       4
`define LOAD_PIPELINE  2
`define WB_SIZE        (`ALU_SIZE + `LOAD_PIPELINE)  // alu slots first, loads after

// ****************************************
// tags and queue
// ****************************************

`define PREG_WIDTH     6
`define IQ_DEPTH       8  // keep a multiple of ALU_SIZE

// alu slots shared with the multi-cycle units
`define CSR_PORT       0
`define MULT_PORT      2
`define DIV_PORT       3

`endif

// File: verilog/wakeup_pkg.sv
`include "wakeup_defs.svh"

package wakeup_pkg;

    // physical register tag
    typedef logic [`PREG_WIDTH-1:0] preg_t;

    // ****************************************
    // issue queue entry
    // ****************************************
    typedef struct packed {
        logic  valid;
        preg_t rs1;
        logic  rs1_ready;  // set at dispatch or by snoop
        preg_t rs2;
        logic  rs2_ready;
        preg_t rd;
        logic  we;         // rd is written
    } iq_entry_t;

endpackage

// File: verilog/wakeup.sv
`timescale 1ns/1ps
`include "wakeup_defs.svh"

// select & wakeup: alu slots announce in the select cycle,
// csr / mult / div take over their slot when they finish
module wakeup (
    input  logic [`ALU_SIZE-1:0]                     alu_en,
    input  logic [`ALU_SIZE-1:0]                     alu_we,
    input  wakeup_pkg::preg_t [`ALU_SIZE-1:0]        alu_rd,
    output logic [`ALU_SIZE-1:0]                     alu_ready,
    input  logic                                     csr_en,
    input  logic                                     csr_we,
    input  wakeup_pkg::preg_t                        csr_rd,
    input  logic                                     mult_en,
    input  logic                                     mult_we,
    input  wakeup_pkg::preg_t                        mult_rd,
    input  logic                                     div_en,
    input  logic                                     div_we,
    input  wakeup_pkg::preg_t                        div_rd,
    input  logic [`LOAD_PIPELINE-1:0]                load_en,
    input  logic [`LOAD_PIPELINE-1:0]                load_we,
    input  wakeup_pkg::preg_t [`LOAD_PIPELINE-1:0]   load_rd,
    output logic [`WB_SIZE-1:0]                      wb_en,
    output logic [`WB_SIZE-1:0]                      wb_we,
    output wakeup_pkg::preg_t [`WB_SIZE-1:0]         wb_rd
);

    // per-slot announcer that outranks the alu
    logic [`ALU_SIZE-1:0]              ext_en;
    logic [`ALU_SIZE-1:0]              ext_we;
    wakeup_pkg::preg_t [`ALU_SIZE-1:0] ext_rd;

    // ****************************************
    // alu slots
    // ****************************************
    for (genvar i = 0; i < `ALU_SIZE; i++) begin : g_alu_slot
        if (i == `CSR_PORT) begin : g_csr
            assign ext_en[i] = csr_en;
            assign ext_we[i] = csr_we;
            assign ext_rd[i] = csr_rd;
        end else if (i == `MULT_PORT) begin : g_mult
            assign ext_en[i] = mult_en;
            assign ext_we[i] = mult_we;
            assign ext_rd[i] = mult_rd;
        end else if (i == `DIV_PORT) begin : g_div
            assign ext_en[i] = div_en;
            assign ext_we[i] = div_we;
            assign ext_rd[i] = div_rd;
        end else begin : g_alu_only
            assign ext_en[i] = 1'b0;  // nobody shares this slot
            assign ext_we[i] = 1'b0;
            assign ext_rd[i] = '0;
        end

        assign alu_ready[i] = ~ext_en[i];  // refuse alu while unit finishes
        assign wb_en[i]     = alu_en[i] | ext_en[i];
        assign wb_we[i]     = ext_en[i] ? ext_we[i] : alu_we[i];
        assign wb_rd[i]     = ext_en[i] ? ext_rd[i] : alu_rd[i];
    end

    // ****************************************
    // load slots, never refused
    // ****************************************
    assign wb_en[`WB_SIZE-1:`ALU_SIZE] = load_en;
    assign wb_we[`WB_SIZE-1:`ALU_SIZE] = load_we;
    assign wb_rd[`WB_SIZE-1:`ALU_SIZE] = load_rd;

endmodule

// File: verilog/issue_queue.sv
`timescale 1ns/1ps
`include "wakeup_defs.svh"

// entry k sits in bank k % ALU_SIZE
module issue_queue (
    input  logic                                clk,
    input  logic                                rst,
    // dispatch
    input  logic                                dis_valid,
    input  wakeup_pkg::preg_t                   dis_rs1,
    input  logic                                dis_rs1_ready,
    input  wakeup_pkg::preg_t                   dis_rs2,
    input  logic                                dis_rs2_ready,
    input  wakeup_pkg::preg_t                   dis_rd,
    input  logic                                dis_we,
    output logic                                dis_ready,
    // issue outputs double as alu wakeups
    input  logic [`ALU_SIZE-1:0]                alu_ready,
    output logic [`ALU_SIZE-1:0]                iss_valid,
    output logic [`ALU_SIZE-1:0]                iss_we,
    output wakeup_pkg::preg_t [`ALU_SIZE-1:0]   iss_rd,
    // wakeup bus snoop
    input  logic [`WB_SIZE-1:0]                 wb_en,
    input  logic [`WB_SIZE-1:0]                 wb_we,
    input  wakeup_pkg::preg_t [`WB_SIZE-1:0]    wb_rd
);

    localparam int BANK_ROWS = `IQ_DEPTH / `ALU_SIZE;

    wakeup_pkg::iq_entry_t entries [`IQ_DEPTH];

    logic [`IQ_DEPTH-1:0] valid_vec;
    logic [`IQ_DEPTH-1:0] req_vec;      // valid with both sources ready
    logic [`IQ_DEPTH-1:0] free_vec;
    logic [`IQ_DEPTH-1:0] alloc_vec;    // one-hot dispatch target
    logic [`IQ_DEPTH-1:0] issue_gnt;
    logic                 dis_fire;
    logic                 dis_rs1_hit;
    logic                 dis_rs2_hit;

    // any bus slot announcing a written tag
    function automatic logic tag_hit(input wakeup_pkg::preg_t tag);
        logic hit;
        hit = 1'b0;
        for (int j = 0; j < `WB_SIZE; j++) begin
            if (wb_en[j] && wb_we[j] && wb_rd[j] == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    always_comb begin
        for (int k = 0; k < `IQ_DEPTH; k++) begin
            valid_vec[k] = entries[k].valid;
            req_vec[k]   = entries[k].valid & entries[k].rs1_ready & entries[k].rs2_ready;
        end
    end

    // ****************************************
    // dispatch into the lowest free entry
    // ****************************************
    assign free_vec    = ~valid_vec;
    assign dis_ready   = |free_vec;
    assign dis_fire    = dis_valid & dis_ready;
    assign alloc_vec   = dis_fire ? (free_vec & -free_vec) : '0;

    // same-cycle wakeup
    always_comb begin
        dis_rs1_hit = tag_hit(dis_rs1);
        dis_rs2_hit = tag_hit(dis_rs2);
    end

    // ****************************************
    // per-port select
    // ****************************************
    for (genvar i = 0; i < `ALU_SIZE; i++) begin : g_port
        logic [BANK_ROWS-1:0] bank_req;
        logic [BANK_ROWS-1:0] bank_gnt;
        wakeup_pkg::preg_t    bank_rd;
        logic                 bank_we;

        for (genvar r = 0; r < BANK_ROWS; r++) begin : g_row
            assign bank_req[r]                = req_vec[r*`ALU_SIZE + i];
            assign issue_gnt[r*`ALU_SIZE + i] = bank_gnt[r];
        end

        // lowest index wins unless the port is refused
        assign bank_gnt = alu_ready[i] ? (bank_req & -bank_req) : '0;

        always_comb begin
            bank_rd = '0;
            bank_we = 1'b0;
            for (int r = 0; r < BANK_ROWS; r++) begin
                if (bank_gnt[r]) begin
                    bank_rd = entries[r*`ALU_SIZE + i].rd;
                    bank_we = entries[r*`ALU_SIZE + i].we;
                end
            end
        end

        assign iss_valid[i] = |bank_gnt;
        assign iss_rd[i]    = bank_rd;
        assign iss_we[i]    = bank_we;
    end

    // ****************************************
    // entry update
    // ****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < `IQ_DEPTH; k++) begin
                entries[k].valid <= 1'b0;
            end
        end else begin
            for (int k = 0; k < `IQ_DEPTH; k++) begin
                if (alloc_vec[k]) begin
                    entries[k].valid     <= 1'b1;
                    entries[k].rs1       <= dis_rs1;
                    entries[k].rs1_ready <= dis_rs1_ready | dis_rs1_hit;
                    entries[k].rs2       <= dis_rs2;
                    entries[k].rs2_ready <= dis_rs2_ready | dis_rs2_hit;
                    entries[k].rd        <= dis_rd;
                    entries[k].we        <= dis_we;
                end else if (entries[k].valid) begin
                    if (issue_gnt[k]) begin
                        entries[k].valid <= 1'b0;  // freed at end of issue cycle
                    end
                    if (tag_hit(entries[k].rs1)) begin
                        entries[k].rs1_ready <= 1'b1;
                    end
                    if (tag_hit(entries[k].rs2)) begin
                        entries[k].rs2_ready <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: verilog/wakeup_top.sv
`timescale 1ns/1ps
`include "wakeup_defs.svh"

module wakeup_top (
    input  logic                                     clk,
    input  logic                                     rst,
    // dispatch
    input  logic                                     dis_valid,
    input  wakeup_pkg::preg_t                        dis_rs1,
    input  logic                                     dis_rs1_ready,
    input  wakeup_pkg::preg_t                        dis_rs2,
    input  logic                                     dis_rs2_ready,
    input  wakeup_pkg::preg_t                        dis_rd,
    input  logic                                     dis_we,
    output logic                                     dis_ready,
    // multi-cycle units and loads
    input  logic                                     csr_en,
    input  logic                                     csr_we,
    input  wakeup_pkg::preg_t                        csr_rd,
    input  logic                                     mult_en,
    input  logic                                     mult_we,
    input  wakeup_pkg::preg_t                        mult_rd,
    input  logic                                     div_en,
    input  logic                                     div_we,
    input  wakeup_pkg::preg_t                        div_rd,
    input  logic [`LOAD_PIPELINE-1:0]                load_en,
    input  logic [`LOAD_PIPELINE-1:0]                load_we,
    input  wakeup_pkg::preg_t [`LOAD_PIPELINE-1:0]   load_rd,
    // issue and bus
    output logic [`ALU_SIZE-1:0]                     iss_valid,
    output logic [`ALU_SIZE-1:0]                     iss_we,
    output wakeup_pkg::preg_t [`ALU_SIZE-1:0]        iss_rd,
    output logic [`WB_SIZE-1:0]                      wb_en,
    output logic [`WB_SIZE-1:0]                      wb_we,
    output wakeup_pkg::preg_t [`WB_SIZE-1:0]         wb_rd
);

    logic [`ALU_SIZE-1:0] alu_ready;  // back-pressure into select

    issue_queue u_iq (
        .clk           (clk),
        .rst           (rst),
        .dis_valid     (dis_valid),
        .dis_rs1       (dis_rs1),
        .dis_rs1_ready (dis_rs1_ready),
        .dis_rs2       (dis_rs2),
        .dis_rs2_ready (dis_rs2_ready),
        .dis_rd        (dis_rd),
        .dis_we        (dis_we),
        .dis_ready     (dis_ready),
        .alu_ready     (alu_ready),
        .iss_valid     (iss_valid),
        .iss_we        (iss_we),
        .iss_rd        (iss_rd),
        .wb_en         (wb_en),  // bus loops back for snoop
        .wb_we         (wb_we),
        .wb_rd         (wb_rd)
    );

    // issue outputs are the alu wakeups
    wakeup u_wakeup (
        .alu_en    (iss_valid),
        .alu_we    (iss_we),
        .alu_rd    (iss_rd),
        .alu_ready (alu_ready),
        .csr_en    (csr_en),
        .csr_we    (csr_we),
        .csr_rd    (csr_rd),
        .mult_en   (mult_en),
        .mult_we   (mult_we),
        .mult_rd   (mult_rd),
        .div_en    (div_en),
        .div_we    (div_we),
        .div_rd    (div_rd),
        .load_en   (load_en),
        .load_we   (load_we),
        .load_rd   (load_rd),
        .wb_en     (wb_en),
        .wb_we     (wb_we),
        .wb_rd     (wb_rd)
    );

endmodule

// File: test/wakeup_chk.sv
`timescale 1ns/1ps
`include "wakeup_defs.svh"

// wakeup block properties, sampled on the queue clock
module wakeup_chk (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`ALU_SIZE-1:0]        alu_en,
    input  logic [`ALU_SIZE-1:0]        alu_ready,
    input  logic                        csr_en,
    input  logic                        mult_en,
    input  logic                        div_en,
    input  logic [`LOAD_PIPELINE-1:0]   load_en,
    input  logic [`WB_SIZE-1:0]         wb_en
);

    // a refused port never issues
    refused_port_idle: assert property (@(posedge clk) disable iff (rst)
        (alu_en & ~alu_ready) == '0)
        else $error("alu port issued while its ready was low");

    csr_slot_en: assert property (@(posedge clk) disable iff (rst)
        wb_en[`CSR_PORT] == (alu_en[`CSR_PORT] | csr_en))
        else $error("csr slot enable is not alu or csr");

    mult_slot_en: assert property (@(posedge clk) disable iff (rst)
        wb_en[`MULT_PORT] == (alu_en[`MULT_PORT] | mult_en))
        else $error("mult slot enable is not alu or mult");

    div_slot_en: assert property (@(posedge clk) disable iff (rst)
        wb_en[`DIV_PORT] == (alu_en[`DIV_PORT] | div_en))
        else $error("div slot enable is not alu or div");

    load_slot_en: assert property (@(posedge clk) disable iff (rst)
        wb_en[`WB_SIZE-1:`ALU_SIZE] == load_en)
        else $error("load slots differ from load_en");

endmodule

// wakeup block ports as seen from the top, alu_en is iss_valid there
bind wakeup_top wakeup_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .alu_en    (iss_valid),
    .alu_ready (alu_ready),
    .csr_en    (csr_en),
    .mult_en   (mult_en),
    .div_en    (div_en),
    .load_en   (load_en),
    .wb_en     (wb_en)
);

// File: test/wakeup_tb.sv
`timescale 1ns/1ps
`include "wakeup_defs.svh"

module wakeup_tb;

    localparam int TEST_CYCLES = 70;  // reset plus all directed tests
    localparam int MAX_CYCLES  = 2 * TEST_CYCLES;
    localparam logic [31:0] ALL_PORTS = (32'd1 << `ALU_SIZE) - 32'd1;

    // fixed tags kept apart from each other
    localparam wakeup_pkg::preg_t TAG_A  = 6'h01;  // always ready source
    localparam wakeup_pkg::preg_t TAG_R1 = 6'h05;
    localparam wakeup_pkg::preg_t TAG_RP = 6'h06;
    localparam wakeup_pkg::preg_t TAG_RC = 6'h07;
    localparam wakeup_pkg::preg_t TAG_R0 = 6'h08;
    localparam wakeup_pkg::preg_t TAG_R4 = 6'h09;
    localparam wakeup_pkg::preg_t TAG_W  = 6'h21;
    localparam wakeup_pkg::preg_t TAG_T  = 6'h22;
    localparam wakeup_pkg::preg_t TAG_T2 = 6'h23;
    localparam wakeup_pkg::preg_t TAG_X  = 6'h2e;
    localparam wakeup_pkg::preg_t TAG_F  = 6'h3a;

    logic clk = 1'b0;
    logic rst;

    logic                                   dis_valid;
    wakeup_pkg::preg_t                      dis_rs1;
    logic                                   dis_rs1_ready;
    wakeup_pkg::preg_t                      dis_rs2;
    logic                                   dis_rs2_ready;
    wakeup_pkg::preg_t                      dis_rd;
    logic                                   dis_we;
    logic                                   dis_ready;
    logic                                   csr_en;
    logic                                   csr_we;
    wakeup_pkg::preg_t                      csr_rd;
    logic                                   mult_en;
    logic                                   mult_we;
    wakeup_pkg::preg_t                      mult_rd;
    logic                                   div_en;
    logic                                   div_we;
    wakeup_pkg::preg_t                      div_rd;
    logic [`LOAD_PIPELINE-1:0]              load_en;
    logic [`LOAD_PIPELINE-1:0]              load_we;
    wakeup_pkg::preg_t [`LOAD_PIPELINE-1:0] load_rd;
    logic [`ALU_SIZE-1:0]                   iss_valid;
    logic [`ALU_SIZE-1:0]                   iss_we;
    wakeup_pkg::preg_t [`ALU_SIZE-1:0]      iss_rd;
    logic [`WB_SIZE-1:0]                    wb_en;
    logic [`WB_SIZE-1:0]                    wb_we;
    wakeup_pkg::preg_t [`WB_SIZE-1:0]       wb_rd;

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    logic [31:0] lfsr   = 32'h5d71_3d33;

    wakeup_top u_dut (
        .clk           (clk),
        .rst           (rst),
        .dis_valid     (dis_valid),
        .dis_rs1       (dis_rs1),
        .dis_rs1_ready (dis_rs1_ready),
        .dis_rs2       (dis_rs2),
        .dis_rs2_ready (dis_rs2_ready),
        .dis_rd        (dis_rd),
        .dis_we        (dis_we),
        .dis_ready     (dis_ready),
        .csr_en        (csr_en),
        .csr_we        (csr_we),
        .csr_rd        (csr_rd),
        .mult_en       (mult_en),
        .mult_we       (mult_we),
        .mult_rd       (mult_rd),
        .div_en        (div_en),
        .div_we        (div_we),
        .div_rd        (div_rd),
        .load_en       (load_en),
        .load_we       (load_we),
        .load_rd       (load_rd),
        .iss_valid     (iss_valid),
        .iss_we        (iss_we),
        .iss_rd        (iss_rd),
        .wb_en         (wb_en),
        .wb_we         (wb_we),
        .wb_rd         (wb_rd)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ****************************************
    // helpers
    // ****************************************

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_tag(output wakeup_pkg::preg_t t);
        for (int b = 0; b < `PREG_WIDTH; b++) begin
            lfsr = lfsr_next(lfsr);
            t[b] = lfsr[0];
        end
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        dis_valid = 1'b0;  // one-cycle strobes
        load_en   = '0;
    endtask

    task automatic settle();
        #10;
    endtask

    task automatic dispatch(input wakeup_pkg::preg_t rs1, input logic rs1_rdy,
                            input wakeup_pkg::preg_t rs2, input logic rs2_rdy,
                            input wakeup_pkg::preg_t rd);
        dis_valid     = 1'b1;
        dis_rs1       = rs1;
        dis_rs1_ready = rs1_rdy;
        dis_rs2       = rs2;
        dis_rs2_ready = rs2_rdy;
        dis_rd        = rd;
        dis_we        = 1'b1;
    endtask

    task automatic announce_load(input wakeup_pkg::preg_t tag);
        load_en[0] = 1'b1;
        load_we[0] = 1'b1;
        load_rd[0] = tag;
    endtask

    task automatic expect_issue(input logic [31:0] mask);
        check("iss_valid", 32'(iss_valid), mask);
    endtask

    // issue port and its bus slot carry the same rd
    task automatic port_matches(input int i, input wakeup_pkg::preg_t rd);
        check($sformatf("iss_rd[%0d]", i), 32'(iss_rd[i]), 32'(rd));
        check($sformatf("iss_we[%0d]", i), 32'(iss_we[i]), 32'd1);
        check($sformatf("wb_rd[%0d]", i), 32'(wb_rd[i]), 32'(rd));
        check($sformatf("wb_we[%0d]", i), 32'(wb_we[i]), 32'd1);
    endtask

    task automatic units_shown(input wakeup_pkg::preg_t c, input wakeup_pkg::preg_t m,
                               input wakeup_pkg::preg_t d);
        check("wb_rd[csr]", 32'(wb_rd[`CSR_PORT]), 32'(c));
        check("wb_rd[mult]", 32'(wb_rd[`MULT_PORT]), 32'(m));
        check("wb_rd[div]", 32'(wb_rd[`DIV_PORT]), 32'(d));
        check("wb_we[csr]", 32'(wb_we[`CSR_PORT]), 32'd1);
        check("wb_we[mult]", 32'(wb_we[`MULT_PORT]), 32'd1);
        check("wb_we[div]", 32'(wb_we[`DIV_PORT]), 32'd1);
    endtask

    // ****************************************
    // directed tests
    // ****************************************

    task automatic reset_test();
        settle();
        check("dis_ready", 32'(dis_ready), 32'd1);
        expect_issue(32'h0);
        check("wb_en", 32'(wb_en), 32'd0);
        next_cycle();
    endtask

    task automatic ready_issue_test();
        wakeup_pkg::preg_t rd_a;
        wakeup_pkg::preg_t rd_q [`ALU_SIZE];
        rand_tag(rd_a);
        for (int i = 0; i < `ALU_SIZE; i++) begin
            rand_tag(rd_q[i]);
        end
        dispatch(TAG_A, 1'b1, TAG_A, 1'b1, rd_a);
        settle();
        expect_issue(32'h0);
        next_cycle();
        settle();
        expect_issue(32'h1);  // one cycle after dispatch
        port_matches(0, rd_a);
        check("wb_en", 32'(wb_en), 32'd1);
        next_cycle();
        // one waiting entry per bank
        for (int i = 0; i < `ALU_SIZE; i++) begin
            dispatch(TAG_W, 1'b0, TAG_A, 1'b1, rd_q[i]);
            settle();
            expect_issue(32'h0);
            next_cycle();
        end
        announce_load(TAG_W);
        settle();
        expect_issue(32'h0);
        check("wb_en", 32'(wb_en), 32'd1 << `ALU_SIZE);
        check("wb_rd[load0]", 32'(wb_rd[`ALU_SIZE]), 32'(TAG_W));
        next_cycle();
        settle();
        expect_issue(ALL_PORTS);
        check("wb_en", 32'(wb_en), ALL_PORTS);
        for (int i = 0; i < `ALU_SIZE; i++) begin
            port_matches(i, rd_q[i]);
        end
        next_cycle();
    endtask

    task automatic chain_test();
        dispatch(TAG_T, 1'b0, TAG_A, 1'b1, TAG_R1);
        settle();
        expect_issue(32'h0);
        next_cycle();
        announce_load(TAG_T);
        load_we[0] = 1'b0;  // announced without a write
        settle();
        expect_issue(32'h0);
        check("wb_we[load0]", 32'(wb_we[`ALU_SIZE]), 32'd0);
        next_cycle();
        settle();
        expect_issue(32'h0);  // still waiting on rs1
        next_cycle();
        announce_load(TAG_T);
        settle();
        expect_issue(32'h0);
        check("wb_en[load0]", 32'(wb_en[`ALU_SIZE]), 32'd1);
        check("wb_rd[load0]", 32'(wb_rd[`ALU_SIZE]), 32'(TAG_T));
        next_cycle();
        settle();
        expect_issue(32'h1);
        port_matches(0, TAG_R1);
        next_cycle();
        // producer in bank 0 feeds a consumer in bank 1
        dispatch(TAG_T2, 1'b0, TAG_A, 1'b1, TAG_RP);
        next_cycle();
        dispatch(TAG_RP, 1'b0, TAG_A, 1'b1, TAG_RC);
        settle();
        expect_issue(32'h0);
        next_cycle();
        announce_load(TAG_T2);
        settle();
        expect_issue(32'h0);
        next_cycle();
        settle();
        expect_issue(32'h1);
        port_matches(0, TAG_RP);
        next_cycle();
        settle();
        expect_issue(32'h2);  // back to back
        port_matches(1, TAG_RC);
        next_cycle();
        // source woken in its own dispatch cycle
        dispatch(TAG_T, 1'b0, TAG_A, 1'b1, TAG_R1);
        announce_load(TAG_T);
        settle();
        expect_issue(32'h0);
        next_cycle();
        settle();
        expect_issue(32'h1);
        port_matches(0, TAG_R1);
        next_cycle();
    endtask

    task automatic preempt_test();
        wakeup_pkg::preg_t unit_rd [3];
        wakeup_pkg::preg_t rd_q [`ALU_SIZE];
        for (int i = 0; i < 3; i++) begin
            do rand_tag(unit_rd[i]); while (unit_rd[i] == TAG_W);
        end
        for (int i = 0; i < `ALU_SIZE; i++) begin
            rand_tag(rd_q[i]);
        end
        csr_en  = 1'b1;
        csr_we  = 1'b1;
        csr_rd  = unit_rd[0];
        mult_en = 1'b1;
        mult_we = 1'b1;
        mult_rd = unit_rd[1];
        div_en  = 1'b1;
        div_we  = 1'b1;
        div_rd  = unit_rd[2];
        for (int i = 0; i < `ALU_SIZE; i++) begin
            dispatch(TAG_W, i != 1, TAG_A, 1'b1, rd_q[i]);  // bank 1 waits
            settle();
            expect_issue(32'h0);
            check("wb_en", 32'(wb_en), 32'hd);
            units_shown(unit_rd[0], unit_rd[1], unit_rd[2]);
            next_cycle();
        end
        announce_load(TAG_W);
        settle();
        expect_issue(32'h0);
        next_cycle();
        settle();
        expect_issue(32'h2);  // port 1 is never refused
        port_matches(1, rd_q[1]);
        check("wb_en", 32'(wb_en), 32'hf);
        units_shown(unit_rd[0], unit_rd[1], unit_rd[2]);
        next_cycle();
        csr_en  = 1'b0;
        mult_en = 1'b0;
        div_en  = 1'b0;
        settle();
        expect_issue(32'hd);
        port_matches(0, rd_q[0]);
        port_matches(2, rd_q[2]);
        port_matches(3, rd_q[3]);
        next_cycle();
    endtask

    task automatic full_test();
        for (int k = 0; k < `IQ_DEPTH; k++) begin
            dispatch(TAG_F, 1'b0, TAG_A, 1'b1, wakeup_pkg::preg_t'(16 + k));
            settle();
            check("dis_ready", 32'(dis_ready), 32'd1);
            expect_issue(32'h0);
            next_cycle();
        end
        // a ready micro-op knocking on a full queue
        dispatch(TAG_A, 1'b1, TAG_A, 1'b1, TAG_X);
        settle();
        check("dis_ready", 32'(dis_ready), 32'd0);
        expect_issue(32'h0);
        next_cycle();
        announce_load(TAG_F);
        settle();
        check("dis_ready", 32'(dis_ready), 32'd0);
        expect_issue(32'h0);
        next_cycle();
        for (int r = 0; r < `IQ_DEPTH / `ALU_SIZE; r++) begin
            settle();
            expect_issue(ALL_PORTS);
            check("dis_ready", 32'(dis_ready), 32'(r > 0));
            for (int i = 0; i < `ALU_SIZE; i++) begin
                port_matches(i, wakeup_pkg::preg_t'(16 + r * `ALU_SIZE + i));
            end
            next_cycle();
        end
        settle();
        expect_issue(32'h0);
        check("dis_ready", 32'(dis_ready), 32'd1);
        next_cycle();
    endtask

    task automatic order_test();
        dispatch(TAG_T, 1'b0, TAG_A, 1'b1, TAG_R0);
        next_cycle();
        for (int i = 1; i < `ALU_SIZE; i++) begin
            dispatch(TAG_T2, 1'b0, TAG_A, 1'b1, wakeup_pkg::preg_t'(48 + i));
            next_cycle();
        end
        dispatch(TAG_T, 1'b0, TAG_A, 1'b1, TAG_R4);  // entry 4 is in bank 0 again
        settle();
        expect_issue(32'h0);
        next_cycle();
        announce_load(TAG_T);
        settle();
        expect_issue(32'h0);
        next_cycle();
        settle();
        expect_issue(32'h1);
        port_matches(0, TAG_R0);
        next_cycle();
        settle();
        expect_issue(32'h1);
        port_matches(0, TAG_R4);
        next_cycle();
        announce_load(TAG_T2);
        next_cycle();
        settle();
        expect_issue(ALL_PORTS & ~32'h1);
        for (int i = 1; i < `ALU_SIZE; i++) begin
            port_matches(i, wakeup_pkg::preg_t'(48 + i));
        end
        next_cycle();
        settle();
        expect_issue(32'h0);
        check("dis_ready", 32'(dis_ready), 32'd1);
        next_cycle();
    endtask

    initial begin
        rst           = 1'b1;
        dis_valid     = 1'b0;
        dis_rs1       = '0;
        dis_rs1_ready = 1'b0;
        dis_rs2       = '0;
        dis_rs2_ready = 1'b0;
        dis_rd        = '0;
        dis_we        = 1'b0;
        csr_en        = 1'b0;
        csr_we        = 1'b0;
        csr_rd        = '0;
        mult_en       = 1'b0;
        mult_we       = 1'b0;
        mult_rd       = '0;
        div_en        = 1'b0;
        div_we        = 1'b0;
        div_rd        = '0;
        load_en       = '0;
        load_we       = '0;
        load_rd       = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        reset_test();
        ready_issue_test();
        chain_test();
        preempt_test();
        full_test();
        order_test();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+verilog
verilog/wakeup_pkg.sv
verilog/wakeup.sv
verilog/issue_queue.sv
verilog/wakeup_top.sv
test/wakeup_chk.sv
test/wakeup_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the wakeup testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
    --top-module wakeup_tb -f project.f -o wakeup_sim

status=0
./obj_dir/wakeup_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi

if [ "$status" -ne 0 ] || ! grep -q "NO ERRORS" sim.log; then
    echo "simulation ended abnormally"
    exit 1
fi

echo "simulation passed"
